/* sources.f */
isa_pkg.sv
pipe_pkg.sv
control_hazard_unit.sv
operand_forward.sv
exec_unit.sv
register_file.sv
data_mem.sv
pipe_regs.sv
cpu_pipe_top.sv
tb_clkgen.sv
tb_cpu_pipe.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the pipeline testbench with Verilator

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f sources.f \
	--top-module tb_cpu_pipe -o tb_cpu_pipe
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_cpu_pipe > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "SIMULATION PASSED" "$LOG"; then
	exit 0
fi
exit 1

/* tb_cpu_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_pipe;
	import isa_pkg::*;
	import pipe_pkg::*;

	localparam int          NUM_INSTR   = 2000;
	localparam int          CYCLE_LIMIT = 3 * NUM_INSTR + 100;
	localparam int unsigned SEED        = 32'h58525384;
	localparam instr_t      NOP_INSTR   = '{opcode: NOP, default: '0};

	// Expected records carry the cycle they must show up in
	typedef struct packed {
		logic [31:0] due;
		wb_t         rec;
	} wb_exp_t;

	typedef struct packed {
		logic [31:0] due;
		store_t      rec;
	} store_exp_t;

	typedef struct packed {
		logic [31:0] due;
		branch_t     rec;
	} branch_exp_t;

	logic    clk;
	logic    rst;
	instr_t  instr;
	logic    stall;
	wb_t     wb;
	store_t  store;
	branch_t branch;

	// Instruction-set model state
	word_t       regs [NUM_REGS];
	word_t       mem [DMEM_DEPTH];
	reg_idx_t    recent [3];
	logic        last_lw;
	reg_idx_t    last_lw_r1;
	wb_exp_t     wb_q [$];
	store_exp_t  st_q [$];
	branch_exp_t br_q [$];

	logic [31:0] cyc = '0;
	int          errors = 0;
	int          accepted_ops = 0;
	int          drained = 0;
	int          taken = 0;
	logic        accept;

	tb_clkgen u_clkgen (
		.clk (clk),
		.rst (rst)
	);

	cpu_pipe_top uut (
		.clk    (clk),
		.rst    (rst),
		.instr  (instr),
		.stall  (stall),
		.wb     (wb),
		.store  (store),
		.branch (branch)
	);

	// ==================================================
	// Reporting helpers
	// ==================================================
	task automatic report_mismatch(input string name, input word_t got, input word_t exp);
		errors++;
		$display("ERR %s: got %h expected %h (cycle %0d)", name, got, exp, cyc);
	endtask

	task automatic report_failure(input string msg);
		errors++;
		$display("%s (cycle %0d)", msg, cyc);
	endtask

	function automatic logic is_branch(input opcode_t op);
		return (op == BE) || (op == BLT) || (op == BGT);
	endfunction

	// ==================================================
	// Random stimulus
	// ==================================================
	// Mostly reuse one of the last three destinations
	function automatic reg_idx_t pick_reg();
		if ($urandom_range(99) < 60)
			return recent[$urandom_range(2)];
		return reg_idx_t'($urandom_range(15, 1));
	endfunction

	function automatic instr_t gen_instr();
		instr_t      t;
		int unsigned sel;
		sel    = $urandom_range(99);
		t.func = func_t'($urandom_range(3));
		t.r1   = pick_reg();
		t.r2   = pick_reg();
		t.imm  = imm_t'($urandom_range(15));
		if (sel < 40)
			t.opcode = ARITHM;
		else if (sel < 55)
			t.opcode = LW;
		else if (sel < 70)
			t.opcode = SW;
		else if (sel < 79)
			t.opcode = BE;
		else if (sel < 87)
			t.opcode = BLT;
		else if (sel < 95)
			t.opcode = BGT;
		else
			t.opcode = NOP;
		return t;
	endfunction

	// ==================================================
	// Sequential model of one accepted instruction
	// ==================================================
	task automatic model_exec(input instr_t t);
		word_t       a;
		word_t       b;
		dmem_addr_t  addr;
		wb_exp_t     we;
		store_exp_t  se;
		branch_exp_t be;
		a          = regs[t.r1];
		b          = regs[t.r2];
		addr       = dmem_addr_t'(b + word_t'(t.imm));
		we         = '0;
		se         = '0;
		be         = '0;
		// Store and branch leave one edge after acceptance and writeback two
		we.due     = cyc + 2;
		se.due     = cyc + 1;
		be.due     = cyc + 1;
		we.rec.idx = t.r1;
		case (t.opcode)
			ARITHM: begin
				case (t.func)
					ADD:     regs[t.r1] = a + b;
					SUB:     regs[t.r1] = a - b;
					MUL:     regs[R0_IDX] = a * b;
					default: regs[R0_IDX] = (b == '0) ? '1 : a / b;
				endcase
				we.rec.en    = (t.func == ADD) || (t.func == SUB);
				we.rec.r0_en = !we.rec.en;
			end
			LW: begin
				regs[t.r1] = mem[addr];
				we.rec.en  = 1'b1;
			end
			SW: begin
				mem[addr] = a;
				se.rec    = '{en: 1'b1, addr: addr, data: a};
				st_q.push_back(se);
			end
			BE, BLT, BGT: begin
				be.rec.valid = 1'b1;
				if (t.opcode == BE)
					be.rec.taken = (a == regs[R0_IDX]);
				else if (t.opcode == BLT)
					be.rec.taken = (a < regs[R0_IDX]);
				else
					be.rec.taken = (a > regs[R0_IDX]);
				br_q.push_back(be);
			end
			default: ;
		endcase
		we.rec.data    = regs[t.r1];
		we.rec.r0_data = regs[R0_IDX];
		if (we.rec.en || we.rec.r0_en)
			wb_q.push_back(we);
		// Remember r1 destinations to bias later operands
		if (we.rec.en) begin
			recent[2] = recent[1];
			recent[1] = recent[0];
			recent[0] = t.r1;
		end
		if (t.opcode != NOP)
			accepted_ops++;
	endtask

	// ==================================================
	// Output checks at each falling edge
	// ==================================================
	task automatic check_idle();
		if (wb.en !== 1'b0)
			report_mismatch("wb.en", word_t'(wb.en), '0);
		if (wb.r0_en !== 1'b0)
			report_mismatch("wb.r0_en", word_t'(wb.r0_en), '0);
		if (store.en !== 1'b0)
			report_mismatch("store.en", word_t'(store.en), '0);
		if (branch.valid !== 1'b0)
			report_mismatch("branch.valid", word_t'(branch.valid), '0);
		if (stall !== 1'b0)
			report_mismatch("stall", word_t'(stall), '0);
	endtask

	task automatic check_outputs();
		wb_exp_t     we;
		store_exp_t  se;
		branch_exp_t be;
		logic        exp_stall;
		// Held branch right behind a load of its r1
		exp_stall = is_branch(instr.opcode) && last_lw && (last_lw_r1 == instr.r1);
		if (stall !== exp_stall)
			report_mismatch("stall", word_t'(stall), word_t'(exp_stall));

		if (store.en === 1'b1) begin
			if (st_q.size() == 0) begin
				report_failure("store appeared with no store expected");
			end else begin
				se = st_q.pop_front();
				drained++;
				if (se.due != cyc)
					report_failure($sformatf("store expected at cycle %0d came late or early",
						se.due));
				if (store.addr !== se.rec.addr)
					report_mismatch("store.addr", word_t'(store.addr), word_t'(se.rec.addr));
				if (store.data !== se.rec.data)
					report_mismatch("store.data", store.data, se.rec.data);
			end
		end else if (st_q.size() != 0 && st_q[0].due <= cyc) begin
			report_failure("expected store never appeared");
			st_q.delete(0);
		end

		if (branch.valid === 1'b1) begin
			if (br_q.size() == 0) begin
				report_failure("branch outcome appeared with no branch expected");
			end else begin
				be = br_q.pop_front();
				drained++;
				if (be.due != cyc)
					report_failure($sformatf("branch expected at cycle %0d came late or early",
						be.due));
				if (branch.taken !== be.rec.taken)
					report_mismatch("branch.taken", word_t'(branch.taken), word_t'(be.rec.taken));
			end
		end else if (br_q.size() != 0 && br_q[0].due <= cyc) begin
			report_failure("expected branch outcome never appeared");
			br_q.delete(0);
		end

		if (wb.en === 1'b1 || wb.r0_en === 1'b1) begin
			if (wb_q.size() == 0) begin
				report_failure("writeback appeared with no writeback expected");
			end else begin
				we = wb_q.pop_front();
				drained++;
				if (we.due != cyc)
					report_failure($sformatf("writeback expected at cycle %0d came late or early",
						we.due));
				if (wb.en !== we.rec.en)
					report_mismatch("wb.en", word_t'(wb.en), word_t'(we.rec.en));
				if (wb.r0_en !== we.rec.r0_en)
					report_mismatch("wb.r0_en", word_t'(wb.r0_en), word_t'(we.rec.r0_en));
				if (we.rec.en && wb.idx !== we.rec.idx)
					report_mismatch("wb.idx", word_t'(wb.idx), word_t'(we.rec.idx));
				if (we.rec.en && wb.data !== we.rec.data)
					report_mismatch("wb.data", wb.data, we.rec.data);
				if (we.rec.r0_en && wb.r0_data !== we.rec.r0_data)
					report_mismatch("wb.r0_data", wb.r0_data, we.rec.r0_data);
			end
		end else if (wb_q.size() != 0 && wb_q[0].due <= cyc) begin
			report_failure("expected writeback never appeared");
			wb_q.delete(0);
		end
	endtask

	// Cycle count and run limit
	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc == CYCLE_LIMIT) begin
			$display("timeout: pipeline did not drain within %0d cycles", CYCLE_LIMIT);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// ==================================================
	// Main sequence
	// ==================================================
	initial begin
		void'($urandom(SEED));
		instr <= NOP_INSTR;
		for (int i = 0; i < NUM_REGS; i++) begin
			regs[i] = '0;
		end
		for (int i = 0; i < DMEM_DEPTH; i++) begin
			mem[i] = '0;
		end
		recent[0]  = 4'd1;
		recent[1]  = 4'd2;
		recent[2]  = 4'd3;
		last_lw    = 1'b0;
		last_lw_r1 = '0;

		// Idle outputs through reset and the first cycle after
		@(negedge clk);
		while (rst) begin
			check_idle();
			@(negedge clk);
		end
		check_idle();

		@(posedge clk);
		instr <= gen_instr();
		while (taken < NUM_INSTR || wb_q.size() != 0 || st_q.size() != 0 ||
				br_q.size() != 0) begin
			@(negedge clk);
			check_outputs();
			// Source holds its instruction while the DUT stalls
			accept = (stall === 1'b0);
			if (accept) begin
				model_exec(instr);
				if (taken < NUM_INSTR)
					taken++;
			end
			last_lw    = accept && (instr.opcode == LW);
			last_lw_r1 = instr.r1;
			@(posedge clk);
			if (accept) begin
				if (taken < NUM_INSTR)
					instr <= gen_instr();
				else
					instr <= NOP_INSTR;
			end
		end

		if (accepted_ops != drained)
			report_failure($sformatf("%0d instructions accepted but %0d records drained",
				accepted_ops, drained));
		$display("accepted=%0d drained=%0d errors=%0d", accepted_ops, drained, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
	parameter int PERIOD_NS  = 10,
	parameter int RST_CYCLES = 16
) (
	output logic clk,
	output logic rst
);

	// Free running clock, first rising edge at half a period
	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Synchronous reset held over the first rising edges
	initial begin
		rst <= 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

/* cpu_pipe_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_pipe_top (
	input  logic              clk,
	input  logic              rst,
	input  isa_pkg::instr_t   instr,
	output logic              stall,
	output pipe_pkg::wb_t     wb,
	output pipe_pkg::store_t  store,
	output pipe_pkg::branch_t branch
);
	import isa_pkg::*;
	import pipe_pkg::*;

	haz_vec_t haz;
	stage_t   s2;
	stage_t   s3;
	stage_t   next;
	branch_t  ex_branch;
	word_t    rf_r1;
	word_t    rf_r2;
	word_t    rf_r0;
	word_t    load_data;
	word_t    s2_val;
	word_t    op_a;
	word_t    op_b;
	word_t    op_r0;

	// ==================================================
	// Stage s1 read, forward, execute
	// ==================================================
	control_hazard_unit u_haz (
		.opcode (instr.opcode),
		.r1     (instr.r1),
		.r2     (instr.r2),
		.s2     (s2),
		.s3     (s3),
		.haz    (haz),
		.stall  (stall)
	);

	register_file u_rf (
		.clk       (clk),
		.rst       (rst),
		.rd_a      (instr.r1),
		.rd_b      (instr.r2),
		.we        (wb.en),
		.wr_idx    (wb.idx),
		.wr_data   (wb.data),
		.r0_we     (wb.r0_en),
		.r0_data   (wb.r0_data),
		.rd_a_data (rf_r1),
		.rd_b_data (rf_r2),
		.rd_r0     (rf_r0)
	);

	// A load in s2 forwards the word being read this cycle
	assign s2_val = (s2.opcode == LW) ? load_data : s2.result;

	operand_forward u_fwd (
		.haz    (haz),
		.rf_r1  (rf_r1),
		.rf_r2  (rf_r2),
		.rf_r0  (rf_r0),
		.s2_val (s2_val),
		.s3_val (s3.result),
		.s2_r0  (s2.r0),
		.s3_r0  (s3.r0),
		.op_a   (op_a),
		.op_b   (op_b),
		.op_r0  (op_r0)
	);

	exec_unit u_exec (
		.instr  (instr),
		.op_a   (op_a),
		.op_b   (op_b),
		.op_r0  (op_r0),
		.next   (next),
		.branch (ex_branch)
	);

	pipe_regs u_regs (
		.clk       (clk),
		.rst       (rst),
		.stall     (stall),
		.next      (next),
		.load_data (load_data),
		.s2        (s2),
		.s3        (s3)
	);

	// ==================================================
	// Stage s2 memory, stage s3 writeback
	// ==================================================
	data_mem u_dmem (
		.clk   (clk),
		.rst   (rst),
		.addr  (s2.addr),
		.we    (store.en),
		.wdata (s2.sdata),
		.rdata (load_data)
	);

	assign store.en   = s2.valid && (s2.opcode == SW);
	assign store.addr = s2.addr;
	assign store.data = s2.sdata;

	// Branch outcome rides alongside s2, dropped while stalled
	always_ff @(posedge clk) begin
		if (rst || stall)
			branch <= '0;
		else
			branch <= ex_branch;
	end

	assign wb.en      = s3.r1_wr;
	assign wb.idx     = s3.r1;
	assign wb.data    = s3.result;
	assign wb.r0_en   = s3.r0_en;
	assign wb.r0_data = s3.r0;

endmodule

`default_nettype wire

/* pipe_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_regs (
	input  logic             clk,
	input  logic             rst,
	input  logic             stall,
	input  pipe_pkg::stage_t next,
	input  isa_pkg::word_t   load_data,
	output pipe_pkg::stage_t s2,
	output pipe_pkg::stage_t s3
);
	import isa_pkg::*;
	import pipe_pkg::*;

	// Empty slot, no writes and no outputs
	localparam stage_t BUBBLE = '{opcode: NOP, default: '0};

	stage_t s3_in;

	// LW picks up its memory data on the way into s3
	always_comb begin
		s3_in = s2;
		if (s2.valid && s2.opcode == LW)
			s3_in.result = load_data;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			s2 <= BUBBLE;
			s3 <= BUBBLE;
		end else begin
			// Held branch stays in s1, s2 gets an empty slot
			s2 <= stall ? BUBBLE : next;
			s3 <= s3_in;
		end
	end

endmodule

`default_nettype wire

/* data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module data_mem (
	input  logic                 clk,
	input  logic                 rst,
	input  pipe_pkg::dmem_addr_t addr,
	input  logic                 we,
	input  isa_pkg::word_t       wdata,
	output isa_pkg::word_t       rdata
);
	import isa_pkg::*;
	import pipe_pkg::*;

	word_t mem [DMEM_DEPTH];

	// Read in the same cycle as the s2 address
	assign rdata = mem[addr];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < DMEM_DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[addr] <= wdata;
		end
	end

endmodule

`default_nettype wire

/* register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file (
	input  logic              clk,
	input  logic              rst,
	input  isa_pkg::reg_idx_t rd_a,
	input  isa_pkg::reg_idx_t rd_b,
	input  logic              we,
	input  isa_pkg::reg_idx_t wr_idx,
	input  isa_pkg::word_t    wr_data,
	input  logic              r0_we,
	input  isa_pkg::word_t    r0_data,
	output isa_pkg::word_t    rd_a_data,
	output isa_pkg::word_t    rd_b_data,
	output isa_pkg::word_t    rd_r0
);
	import isa_pkg::*;

	word_t regs [NUM_REGS];

	// Combinational reads, s3 forwarding covers the write cycle
	assign rd_a_data = regs[rd_a];
	assign rd_b_data = regs[rd_b];
	assign rd_r0     = regs[R0_IDX];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else begin
			// Indexed write never targets R0, both may land together
			if (we)
				regs[wr_idx] <= wr_data;
			if (r0_we)
				regs[R0_IDX] <= r0_data;
		end
	end

endmodule

`default_nettype wire

/* exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
	input  isa_pkg::instr_t   instr,
	input  isa_pkg::word_t    op_a,
	input  isa_pkg::word_t    op_b,
	input  isa_pkg::word_t    op_r0,
	output pipe_pkg::stage_t  next,
	output pipe_pkg::branch_t branch
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic  is_arith;
	logic  is_branch;
	word_t mul_lo;
	word_t quot;

	assign is_arith  = (instr.opcode == ARITHM);
	assign is_branch = (instr.opcode == BE) || (instr.opcode == BLT) ||
		(instr.opcode == BGT);

	// Low half of the product only
	assign mul_lo = op_a * op_b;
	// Zero divisor saturates to all ones
	assign quot   = (op_b == '0) ? '1 : op_a / op_b;

	// ==================================================
	// Next s2 record
	// ==================================================
	always_comb begin
		next        = '0;
		next.valid  = (instr.opcode != NOP);
		next.opcode = instr.opcode;
		next.r1     = instr.r1;
		next.r1_wr  = (is_arith && (instr.func == ADD || instr.func == SUB)) ||
			(instr.opcode == LW);
		next.r0_en  = is_arith && (instr.func == MUL || instr.func == DIV);
		// MUL/DIV pass r1 through unchanged
		case (instr.func)
			ADD:     next.result = op_a + op_b;
			SUB:     next.result = op_a - op_b;
			default: next.result = op_a;
		endcase
		next.r0    = (instr.func == MUL) ? mul_lo : quot;
		// Low 4 bits of base plus offset
		next.addr  = op_b[DMEM_AW-1:0] + instr.imm;
		next.sdata = op_a;
	end

	// Unsigned compare of r1 against R0
	always_comb begin
		branch.valid = is_branch;
		case (instr.opcode)
			BE:      branch.taken = (op_a == op_r0);
			BLT:     branch.taken = (op_a < op_r0);
			BGT:     branch.taken = (op_a > op_r0);
			default: branch.taken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* operand_forward.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_forward (
	input  pipe_pkg::haz_vec_t haz,
	input  isa_pkg::word_t     rf_r1,
	input  isa_pkg::word_t     rf_r2,
	input  isa_pkg::word_t     rf_r0,
	input  isa_pkg::word_t     s2_val,
	input  isa_pkg::word_t     s3_val,
	input  isa_pkg::word_t     s2_r0,
	input  isa_pkg::word_t     s3_r0,
	output isa_pkg::word_t     op_a,
	output isa_pkg::word_t     op_b,
	output isa_pkg::word_t     op_r0
);
	import isa_pkg::*;
	import pipe_pkg::*;

	// Selects are one-hot per operand, order only documents priority
	function automatic word_t pick(input logic from_s2, input logic from_s3,
			input word_t rf, input word_t v2, input word_t v3);
		if (from_s2)
			return v2;
		else if (from_s3)
			return v3;
		return rf;
	endfunction

	// First source, also the store data and branch operand
	assign op_a  = pick(haz[HAZ_R1_S2], haz[HAZ_R1_S3], rf_r1, s2_val, s3_val);
	// Second source, also the address base
	assign op_b  = pick(haz[HAZ_R2_S2], haz[HAZ_R2_S3], rf_r2, s2_val, s3_val);
	// Implicit R0 for branch compares
	assign op_r0 = pick(haz[HAZ_R0_S2], haz[HAZ_R0_S3], rf_r0, s2_r0, s3_r0);

endmodule

`default_nettype wire

/* control_hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module control_hazard_unit (
	input  isa_pkg::opcode_t  opcode,
	input  isa_pkg::reg_idx_t r1,
	input  isa_pkg::reg_idx_t r2,
	input  pipe_pkg::stage_t  s2,
	input  pipe_pkg::stage_t  s3,
	output pipe_pkg::haz_vec_t haz,
	output logic              stall
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic is_branch;
	logic r1_s2;
	logic r1_s3;
	logic r2_s2;
	logic r2_s3;

	// Compare against r1 and R0 only
	assign is_branch = (opcode == BE) || (opcode == BLT) || (opcode == BGT);

	// ==================================================
	// Register matches against older writers
	// ==================================================
	// r1_wr is only ever set on a valid ADD/SUB or LW record
	assign r1_s2 = s2.r1_wr && (s2.r1 == r1);
	assign r1_s3 = s3.r1_wr && (s3.r1 == r1);
	assign r2_s2 = s2.r1_wr && (s2.r1 == r2);
	assign r2_s3 = s3.r1_wr && (s3.r1 == r2);

	// s2 holds the younger value, so it beats s3
	// Selects for operands an opcode ignores are harmless
	assign haz[HAZ_R1_S2] = r1_s2;
	assign haz[HAZ_R1_S3] = r1_s3 && !r1_s2;
	assign haz[HAZ_R2_S2] = r2_s2;
	assign haz[HAZ_R2_S3] = r2_s3 && !r2_s2;

	// R0 is implicit for every branch, no index to compare
	assign haz[HAZ_R0_S2] = is_branch && s2.r0_en;
	assign haz[HAZ_R0_S3] = is_branch && s3.r0_en && !s2.r0_en;

	// ==================================================
	// Load directly ahead of a branch on its destination
	// ==================================================
	// Hold the branch one cycle so the compare sees the
	// loaded value from s3 instead of the memory read path
	assign stall = is_branch && s2.valid && (s2.opcode == LW) && (s2.r1 == r1);

endmodule

`default_nettype wire

/* pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

	// Forwarding selects, one bit per operand and source stage
	localparam int HAZ_W = 6;
	typedef logic [HAZ_W-1:0] haz_vec_t;

	localparam int HAZ_R1_S2 = 0;
	localparam int HAZ_R1_S3 = 1;
	localparam int HAZ_R2_S2 = 2;
	localparam int HAZ_R2_S3 = 3;
	localparam int HAZ_R0_S2 = 4;
	localparam int HAZ_R0_S3 = 5;

	// Data memory geometry
	localparam int DMEM_DEPTH = 16;
	localparam int DMEM_AW    = $clog2(DMEM_DEPTH);
	typedef logic [DMEM_AW-1:0] dmem_addr_t;

	// ==================================================
	// Per-stage record and port bundles
	// ==================================================
	typedef struct packed {
		logic              valid;
		isa_pkg::opcode_t  opcode;
		isa_pkg::reg_idx_t r1;
		logic              r1_wr;
		logic              r0_en;
		isa_pkg::word_t    result;
		isa_pkg::word_t    r0;
		dmem_addr_t        addr;
		isa_pkg::word_t    sdata;
	} stage_t;

	typedef struct packed {
		logic              en;
		isa_pkg::reg_idx_t idx;
		isa_pkg::word_t    data;
		logic              r0_en;
		isa_pkg::word_t    r0_data;
	} wb_t;

	typedef struct packed {
		logic           en;
		dmem_addr_t     addr;
		isa_pkg::word_t data;
	} store_t;

	typedef struct packed {
		logic valid;
		logic taken;
	} branch_t;

endpackage

`default_nettype wire

/* isa_pkg.sv */
`default_nettype none

package isa_pkg;

	// ==================================================
	// Machine widths
	// ==================================================
	localparam int NUM_REGS  = 16;
	localparam int DATA_W    = 16;
	localparam int REG_IDX_W = $clog2(NUM_REGS);
	localparam int IMM_W     = 4;

	typedef logic [DATA_W-1:0]    word_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;
	typedef logic [IMM_W-1:0]     imm_t;

	// Implicit accumulator for MUL/DIV results and branch compares
	localparam reg_idx_t R0_IDX = '0;

	// ==================================================
	// Instruction encoding
	// ==================================================
	typedef enum logic [3:0] {
		ARITHM = 4'h0,
		LW     = 4'h1,
		SW     = 4'h2,
		BE     = 4'h3,
		BLT    = 4'h4,
		BGT    = 4'h5,
		NOP    = 4'hf
	} opcode_t;

	// Arithmetic function field, MUL and DIV target R0
	typedef logic [1:0] func_t;
	localparam func_t ADD = 2'd0;
	localparam func_t SUB = 2'd1;
	localparam func_t MUL = 2'd2;
	localparam func_t DIV = 2'd3;

	// 18-bit instruction word
	typedef struct packed {
		opcode_t  opcode;
		func_t    func;
		reg_idx_t r1;
		reg_idx_t r2;
		imm_t     imm;
	} instr_t;

endpackage

`default_nettype wire
